/* hdl/seq_pkg.sv */
// Input word union, operation, buffer entry, issue and result types with their field widths
package seq_pkg;

    ////////////////////
    // Field widths
    ////////////////////

    localparam int unsigned OpcodeWidth  = 7;
    localparam int unsigned RegWidth     = 8;
    localparam int unsigned BodyLenWidth = 8;
    localparam int unsigned RepWidth     = 16;
    localparam int unsigned SeqNoWidth   = 16;

    ////////////////////
    // Input word views
    ////////////////////

    // Operation view, kind is 0
    typedef struct packed {
        logic                   kind;
        logic [OpcodeWidth-1:0] opcode;
        logic [RegWidth-1:0]    rd;
        logic [RegWidth-1:0]    rs1;
        logic [RegWidth-1:0]    rs2;
    } seq_op_t;

    // Repeat header view, kind is 1
    // The body is issued rep_cnt+1 times
    typedef struct packed {
        logic                    kind;
        logic [OpcodeWidth-1:0]  reserved;
        logic [BodyLenWidth-1:0] body_len;
        logic [RepWidth-1:0]     rep_cnt;
    } seq_frep_t;

    // Both views put the kind bit at bit 31, so either one can be used to test it
    typedef union packed {
        seq_op_t   op;
        seq_frep_t frep;
    } seq_word_u;

    ////////////////////
    // Pipeline types
    ////////////////////

    // One ring buffer slot
    // A plain operation carries head 0, body_len 1 and rep_cnt 0
    typedef struct packed {
        seq_op_t                 op;
        logic                    head;
        logic [BodyLenWidth-1:0] body_len;
        logic [RepWidth-1:0]     rep_cnt;
    } seq_entry_t;

    // Operation leaving the execute stage with its repetition index
    typedef struct packed {
        seq_op_t             op;
        logic [RepWidth-1:0] iter;
    } seq_issue_t;

    // Operation as presented at the top-level output
    typedef struct packed {
        seq_op_t               op;
        logic [RepWidth-1:0]   iter;
        logic [SeqNoWidth-1:0] seq_no;
    } seq_result_t;

endpackage

/* hdl/ring_buffer.sv */
// Ring buffer with sequential writes, range-checked random reads and stepped read pointer
`timescale 1ns/1ps

module ring_buffer #(
    parameter int unsigned Depth = 16,
    parameter type data_t = logic,
    localparam int unsigned AddrWidth = $clog2(Depth),
    localparam int unsigned StepWidth = $clog2(Depth + 1)
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    // Sequential write port
    input  logic                 wvalid_i,
    output logic                 wready_o,
    input  data_t                wdata_i,

    // Random read port, limited to the occupied slots
    input  logic                 rvalid_i,
    output logic                 rready_o,
    input  logic [AddrWidth-1:0] raddr_i,
    output data_t                rdata_o,

    // Frees step_i entries at the read pointer
    input  logic                 advance_i,
    input  logic [StepWidth-1:0] step_i,

    output logic [AddrWidth-1:0] wptr_o,
    output logic [AddrWidth-1:0] rptr_o,
    output logic                 full_o,
    output logic                 empty_o
);

    ////////////////////
    // Storage
    ////////////////////

    data_t mem_q [Depth];

    // The extra top bit tells a full buffer from an empty one
    logic [AddrWidth:0] wptr_q;
    logic [AddrWidth:0] rptr_q;

    // Number of occupied slots, from 0 up to Depth
    logic [AddrWidth:0] fill;

    // Distance of the requested address from the read pointer, modulo Depth
    logic [AddrWidth-1:0] rdist;

    logic wr_fire;

    assign wr_fire = wvalid_i && wready_o;

    always_ff @(posedge clk_i) begin
        if (wr_fire) begin
            mem_q[wptr_q[AddrWidth-1:0]] <= wdata_i;
        end
    end

    ////////////////////
    // Pointers
    ////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wptr_q <= '0;
            rptr_q <= '0;
        end else begin
            if (wr_fire) begin
                wptr_q <= wptr_q + 1'b1;
            end
            // The step is zero-extended to the pointer width and wraps with it
            if (advance_i) begin
                rptr_q <= rptr_q + (AddrWidth + 1)'(step_i);
            end
        end
    end

    ////////////////////
    // Status and read
    ////////////////////

    assign fill    = wptr_q - rptr_q;
    assign empty_o = (fill == '0);
    assign full_o  = fill[AddrWidth];
    assign wptr_o  = wptr_q[AddrWidth-1:0];
    assign rptr_o  = rptr_q[AddrWidth-1:0];

    assign wready_o = !full_o;

    // An address is readable when its offset from the read pointer is below the fill level,
    // which covers the wrapped case and the full buffer without separate terms
    assign rdist    = raddr_i - rptr_o;
    assign rready_o = ({1'b0, rdist} < fill);

    // Data is returned in the same cycle as the address
    assign rdata_o = mem_q[raddr_i];

endmodule

/* hdl/seq_decode.sv */
// Input decoder that separates repeat headers from operations and writes tagged buffer entries
`timescale 1ns/1ps

module seq_decode (
    input  logic               clk_i,
    input  logic               rst_n_i,

    input  logic               in_valid_i,
    output logic               in_ready_o,
    input  seq_pkg::seq_word_u in_word_i,

    output logic               wvalid_o,
    input  logic               wready_i,
    output seq_pkg::seq_entry_t wdata_o
);

    import seq_pkg::*;

    // Header waiting for the first operation of its body
    logic                    pend_q;
    logic [BodyLenWidth-1:0] pend_len_q;
    logic [RepWidth-1:0]     pend_rep_q;

    logic is_hdr;
    logic hdr_fire;
    logic op_fire;

    // The kind bit sits at the same position in both views
    assign is_hdr = in_word_i.frep.kind;

    // A header only needs a free pending slot, an operation needs buffer space
    assign in_ready_o = is_hdr ? !pend_q : wready_i;
    assign wvalid_o   = in_valid_i && !is_hdr;

    assign hdr_fire = in_valid_i && is_hdr && !pend_q;
    assign op_fire  = wvalid_o && wready_i;

    ////////////////////
    // Entry build
    ////////////////////

    always_comb begin
        wdata_o.op = in_word_i.op;
        if (pend_q) begin
            // First body operation carries the loop description
            wdata_o.head     = 1'b1;
            wdata_o.body_len = pend_len_q;
            wdata_o.rep_cnt  = pend_rep_q;
        end else begin
            wdata_o.head     = 1'b0;
            wdata_o.body_len = BodyLenWidth'(1);
            wdata_o.rep_cnt  = '0;
        end
    end

    ////////////////////
    // Pending header
    ////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pend_q <= 1'b0;
        end else if (hdr_fire) begin
            pend_q <= 1'b1;
        end else if (op_fire) begin
            pend_q <= 1'b0;
        end
    end

    // Loop fields are only looked at while pend_q is set
    always_ff @(posedge clk_i) begin
        if (hdr_fire) begin
            pend_len_q <= in_word_i.frep.body_len;
            pend_rep_q <= in_word_i.frep.rep_cnt;
        end
    end

endmodule

/* hdl/seq_execute.sv */
// Loop controller that re-reads buffer entries by address, repeats bodies and frees entries
`timescale 1ns/1ps

module seq_execute #(
    parameter int unsigned Depth = 16,
    localparam int unsigned AddrWidth = $clog2(Depth),
    localparam int unsigned StepWidth = $clog2(Depth + 1)
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    // Ring buffer read port
    output logic                 rvalid_o,
    input  logic                 rready_i,
    output logic [AddrWidth-1:0] raddr_o,
    input  seq_pkg::seq_entry_t  rdata_i,

    // Ring buffer release
    output logic                 advance_o,
    output logic [StepWidth-1:0] step_o,

    input  logic [AddrWidth-1:0] rptr_i,
    input  logic                 empty_i,

    // Issue towards the result stage
    output logic                 iss_valid_o,
    input  logic                 iss_ready_i,
    output seq_pkg::seq_issue_t  iss_o,

    output logic                 busy_o
);

    import seq_pkg::*;

    ////////////////////
    // Loop state
    ////////////////////

    // Set while a body is partly issued, cleared on the last operation of the last pass
    logic                    active_q;
    logic [BodyLenWidth-1:0] off_q;
    logic [RepWidth-1:0]     iter_q;
    logic [BodyLenWidth-1:0] len_q;
    logic [RepWidth-1:0]     rep_q;

    // Loop description in force this cycle
    logic [BodyLenWidth-1:0] cur_len;
    logic [RepWidth-1:0]     cur_rep;

    logic fire;
    logic last_op;
    logic last_iter;

    // When idle the entry at the read pointer starts the next loop, so its fields are used
    // straight from the buffer. A non-head entry is a single operation
    always_comb begin
        if (active_q) begin
            cur_len = len_q;
            cur_rep = rep_q;
        end else if (rdata_i.head) begin
            cur_len = rdata_i.body_len;
            cur_rep = rdata_i.rep_cnt;
        end else begin
            cur_len = BodyLenWidth'(1);
            cur_rep = '0;
        end
    end

    // The offset wraps with the address width, matching the ring buffer slots
    assign raddr_o  = rptr_i + AddrWidth'(off_q);
    assign rvalid_o = active_q || !empty_i;

    // A body operation that is not yet written keeps rready_i low
    assign iss_valid_o = rvalid_o && rready_i;
    assign iss_o.op    = rdata_i.op;
    assign iss_o.iter  = iter_q;

    assign fire      = iss_valid_o && iss_ready_i;
    assign last_op   = (off_q == cur_len - BodyLenWidth'(1));
    assign last_iter = (iter_q == cur_rep);

    // Entries are released together with the final issue, so the pointer moves at the same edge
    assign advance_o = fire && last_op && last_iter;
    assign step_o    = StepWidth'(cur_len);

    assign busy_o = active_q;

    ////////////////////
    // Counters
    ////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            active_q <= 1'b0;
            off_q    <= '0;
            iter_q   <= '0;
        end else if (fire) begin
            if (!last_op) begin
                off_q    <= off_q + 1'b1;
                active_q <= 1'b1;
            end else if (!last_iter) begin
                // Body done, start the next pass from its first entry
                off_q    <= '0;
                iter_q   <= iter_q + 1'b1;
                active_q <= 1'b1;
            end else begin
                off_q    <= '0;
                iter_q   <= '0;
                active_q <= 1'b0;
            end
        end
    end

    // Latched on the first issue of a loop and held until it finishes
    always_ff @(posedge clk_i) begin
        if (fire && !active_q) begin
            len_q <= cur_len;
            rep_q <= cur_rep;
        end
    end

endmodule

/* hdl/seq_result.sv */
// Output register that stamps issue sequence numbers and holds results under back-pressure
`timescale 1ns/1ps

module seq_result (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  logic                 iss_valid_i,
    output logic                 iss_ready_o,
    input  seq_pkg::seq_issue_t  iss_i,

    output logic                 out_valid_o,
    input  logic                 out_ready_i,
    output seq_pkg::seq_result_t out_result_o
);

    import seq_pkg::*;

    logic                  valid_q;
    seq_result_t           result_q;
    logic [SeqNoWidth-1:0] seq_q;

    logic iss_fire;

    // The register takes a new result when empty or while its content is being taken
    assign iss_ready_o = !valid_q || out_ready_i;
    assign iss_fire    = iss_valid_i && iss_ready_o;

    ////////////////////
    // Control
    ////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            seq_q   <= '0;
        end else if (iss_fire) begin
            valid_q <= 1'b1;
            // Running count of issued operations, wraps at the field width
            seq_q   <= seq_q + 1'b1;
        end else if (out_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    // Payload only changes on a new issue, so it stays put while out_ready_i is low
    always_ff @(posedge clk_i) begin
        if (iss_fire) begin
            result_q.op     <= iss_i.op;
            result_q.iter   <= iss_i.iter;
            result_q.seq_no <= seq_q;
        end
    end

    assign out_valid_o  = valid_q;
    assign out_result_o = result_q;

endmodule

/* hdl/frep_sequencer.sv */
// Top level of the repetition sequencer joining decode, ring buffer, execute and result stages
`timescale 1ns/1ps

module frep_sequencer #(
    parameter int unsigned Depth = 16
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  logic                 in_valid_i,
    output logic                 in_ready_o,
    input  seq_pkg::seq_word_u   in_word_i,

    output logic                 out_valid_o,
    input  logic                 out_ready_i,
    output seq_pkg::seq_result_t out_result_o,

    output logic                 idle_o
);

    import seq_pkg::*;

    localparam int unsigned AddrWidth = $clog2(Depth);
    localparam int unsigned StepWidth = $clog2(Depth + 1);

    ////////////////////
    // Internal wiring
    ////////////////////

    // Decode to buffer
    logic       wvalid;
    logic       wready;
    seq_entry_t wdata;

    // Execute to buffer
    logic                 rvalid;
    logic                 rready;
    logic [AddrWidth-1:0] raddr;
    seq_entry_t           rdata;
    logic                 advance;
    logic [StepWidth-1:0] step;
    logic [AddrWidth-1:0] rptr;
    logic                 empty;

    // Execute to result
    logic       iss_valid;
    logic       iss_ready;
    seq_issue_t iss;

    logic exe_busy;

    seq_decode i_decode (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .in_valid_i (in_valid_i),
        .in_ready_o (in_ready_o),
        .in_word_i  (in_word_i),
        .wvalid_o   (wvalid),
        .wready_i   (wready),
        .wdata_o    (wdata)
    );

    // Full and write pointer status are not needed here, wready already reflects fullness
    ring_buffer #(
        .Depth  (Depth),
        .data_t (seq_entry_t)
    ) i_ring_buffer (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .wvalid_i  (wvalid),
        .wready_o  (wready),
        .wdata_i   (wdata),
        .rvalid_i  (rvalid),
        .rready_o  (rready),
        .raddr_i   (raddr),
        .rdata_o   (rdata),
        .advance_i (advance),
        .step_i    (step),
        .wptr_o    (),
        .rptr_o    (rptr),
        .full_o    (),
        .empty_o   (empty)
    );

    seq_execute #(
        .Depth (Depth)
    ) i_execute (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .rvalid_o    (rvalid),
        .rready_i    (rready),
        .raddr_o     (raddr),
        .rdata_i     (rdata),
        .advance_o   (advance),
        .step_o      (step),
        .rptr_i      (rptr),
        .empty_i     (empty),
        .iss_valid_o (iss_valid),
        .iss_ready_i (iss_ready),
        .iss_o       (iss),
        .busy_o      (exe_busy)
    );

    seq_result i_result (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .iss_valid_i  (iss_valid),
        .iss_ready_o  (iss_ready),
        .iss_i        (iss),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_result_o (out_result_o)
    );

    // Nothing stored, nothing in flight and nothing waiting at the output
    assign idle_o = empty && !exe_busy && !out_valid_o;

endmodule

/* test/tb_clk_gen.sv */
// Testbench clock source and power-on reset
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int unsigned PeriodNs    = 40,
    parameter int unsigned ResetCycles = 4
) (
    output logic clk_o,
    output logic rst_n_o
);

    // Free-running clock, starts low
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PeriodNs / 2);
            clk_o = ~clk_o;
        end
    end

    // Reset goes away on a falling edge, well clear of the sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (ResetCycles) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

/* test/frep_sequencer_chk.sv */
// Bound assertions for ring buffer pointer ordering, write stalls and read range
`timescale 1ns/1ps

module frep_sequencer_chk #(
    parameter int unsigned Depth = 16,
    parameter type data_t = logic,
    localparam int unsigned AddrWidth = $clog2(Depth),
    localparam int unsigned StepWidth = $clog2(Depth + 1)
) (
    input logic                 clk_i,
    input logic                 rst_n_i,
    input logic                 wvalid_i,
    input logic                 wready_i,
    input data_t                wdata_i,
    input logic                 rvalid_i,
    input logic                 rready_i,
    input logic [AddrWidth-1:0] raddr_i,
    input logic                 advance_i,
    input logic [StepWidth-1:0] step_i,
    // Full-width pointers including the wrap bit
    input logic [AddrWidth:0]   wptr_i,
    input logic [AddrWidth:0]   rptr_i
);

    // Number of failed assertions, read by the testbench at the end of the run
    int fail_cnt = 0;

    // Occupancy counted from accepted writes and released steps
    int occ_q;

    logic [AddrWidth:0] fill;
    logic               same_lap;
    logic               above_rptr;
    logic               below_wptr;
    logic               in_range;

    // A read pointer that overtakes the write pointer shows up as a fill above Depth
    assign fill = wptr_i - rptr_i;

    // Both pointers on the same lap means the occupied slots do not wrap
    assign same_lap   = (wptr_i[AddrWidth] == rptr_i[AddrWidth]);
    assign above_rptr = (raddr_i >= rptr_i[AddrWidth-1:0]);
    assign below_wptr = (raddr_i < wptr_i[AddrWidth-1:0]);
    assign in_range   = same_lap ? (above_rptr && below_wptr) : (above_rptr || below_wptr);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            occ_q <= 0;
        end else begin
            occ_q <= occ_q + int'(wvalid_i && wready_i) - (advance_i ? int'(step_i) : 0);
        end
    end

    rptr_behind_wptr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fill <= Depth)
        else begin
            $error("read pointer passed the write pointer, fill %0d", fill);
            fail_cnt++;
        end

    no_write_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (wvalid_i && wready_i) |-> (occ_q < int'(Depth)))
        else begin
            $error("write accepted while the buffer is full, occupancy %0d", occ_q);
            fail_cnt++;
        end

    // The producer has to keep offering the same entry until it goes in
    stalled_write_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (wvalid_i && !wready_i) |=> (wvalid_i && $stable(wdata_i)))
        else begin
            $error("stalled write dropped valid or changed its data");
            fail_cnt++;
        end

    read_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (rvalid_i && rready_i) |-> in_range)
        else begin
            $error("read at address %0h accepted outside the occupied range", raddr_i);
            fail_cnt++;
        end

endmodule

/* test/frep_sequencer_tb.sv */
// Testbench top for the repetition sequencer, driven from the cases file
`timescale 1ns/1ps

module frep_sequencer_tb;

    import seq_pkg::*;

    localparam int unsigned Depth     = 16;
    localparam int unsigned WaitLimit = 2000;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic        in_ready;
    seq_word_u   in_word;
    logic        out_valid;
    logic        out_ready;
    seq_result_t out_result;
    logic        idle;

    ////////////////////
    // Case state
    ////////////////////

    string               case_name;
    int                  case_gap;
    int                  case_hold;
    logic [31:0]         word_q[$];
    seq_op_t             exp_op_q[$];
    logic [RepWidth-1:0] exp_iter_q[$];
    seq_result_t         got_q[$];

    // Sequence numbers only restart on reset, so this runs across all cases
    logic [SeqNoWidth-1:0] exp_seq_no;
    logic                  driving;
    logic                  saw_block;
    int                    case_cnt;
    int                    check_cnt;
    int                    error_cnt;

    tb_clk_gen #(
        .PeriodNs    (40),
        .ResetCycles (4)
    ) i_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    frep_sequencer #(
        .Depth (Depth)
    ) DUT (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .in_valid_i   (in_valid),
        .in_ready_o   (in_ready),
        .in_word_i    (in_word),
        .out_valid_o  (out_valid),
        .out_ready_i  (out_ready),
        .out_result_o (out_result),
        .idle_o       (idle)
    );

    bind ring_buffer frep_sequencer_chk #(
        .Depth  (Depth),
        .data_t (data_t)
    ) i_chk (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .wvalid_i  (wvalid_i),
        .wready_i  (wready_o),
        .wdata_i   (wdata_i),
        .rvalid_i  (rvalid_i),
        .rready_i  (rready_o),
        .raddr_i   (raddr_i),
        .advance_i (advance_i),
        .step_i    (step_i),
        .wptr_i    (wptr_q),
        .rptr_i    (rptr_q)
    );

    ////////////////////
    // Checks
    ////////////////////

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display("test failed");
        $finish;
    endtask

    task automatic compare_op(input int idx, input seq_op_t got, input seq_op_t exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("MISMATCH %s result %0d op: got %h expected %h", case_name, idx, got, exp);
        end
    endtask

    task automatic compare_iter(input int idx, input logic [RepWidth-1:0] got,
                                input logic [RepWidth-1:0] exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("MISMATCH %s result %0d iter: got %h expected %h", case_name, idx, got, exp);
        end
    endtask

    task automatic compare_seq_no(input int idx, input logic [SeqNoWidth-1:0] got,
                                  input logic [SeqNoWidth-1:0] exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("MISMATCH %s result %0d seq_no: got %h expected %h",
                     case_name, idx, got, exp);
        end
    endtask

    ////////////////////
    // Stimulus and capture
    ////////////////////

    // Offers each word until the DUT takes it, then idles for the case gap
    task automatic drive_words();
        int wait_cnt;
        foreach (word_q[i]) begin
            in_valid = 1'b1;
            in_word  = word_q[i];
            wait_cnt = 0;
            do begin
                @(posedge clk);
                if (!in_ready) begin
                    saw_block = 1'b1;
                end
                wait_cnt++;
                if (wait_cnt > WaitLimit) begin
                    abort_run($sformatf("input word %0d of case %s was never accepted",
                                        i, case_name));
                end
            end while (!in_ready);
            @(negedge clk);
            in_valid = 1'b0;
            repeat (case_gap) @(negedge clk);
        end
        driving = 1'b0;
    endtask

    // Takes results until everything expected is in and the DUT has gone idle
    task automatic collect_results();
        int wait_cnt;
        bit done;
        wait_cnt = 0;
        done     = 1'b0;
        while (!done) begin
            @(negedge clk);
            // A hold case blocks the output until the input side has backed up
            if (case_hold != 0 && driving && !saw_block) begin
                out_ready = 1'b0;
            end else begin
                out_ready = ($urandom % 4) != 0;
            end
            @(posedge clk);
            if (out_valid && out_ready) begin
                got_q.push_back(out_result);
            end
            done = !driving && idle && (got_q.size() >= exp_op_q.size());
            wait_cnt++;
            if (wait_cnt > WaitLimit) begin
                abort_run($sformatf("timeout waiting for results of case %s", case_name));
            end
        end
    endtask

    task automatic run_case();
        int errs_before;
        errs_before = error_cnt;
        saw_block   = 1'b0;
        driving     = 1'b1;
        got_q.delete();
        @(negedge clk);
        fork
            drive_words();
            collect_results();
        join
        if (got_q.size() != exp_op_q.size()) begin
            error_cnt++;
            $display("case %s returned %0d results where %0d were expected",
                     case_name, got_q.size(), exp_op_q.size());
        end
        foreach (got_q[i]) begin
            if (i < exp_op_q.size()) begin
                compare_op(i, got_q[i].op, exp_op_q[i]);
                compare_iter(i, got_q[i].iter, exp_iter_q[i]);
                compare_seq_no(i, got_q[i].seq_no, exp_seq_no + SeqNoWidth'(i));
            end
        end
        exp_seq_no = exp_seq_no + SeqNoWidth'(exp_op_q.size());
        if (case_hold != 0 && !saw_block) begin
            error_cnt++;
            $display("case %s never saw the input stall while the output was held", case_name);
        end
        $display("case %-8s %0d results, %0d errors", case_name, got_q.size(),
                 error_cnt - errs_before);
        case_cnt++;
        word_q.delete();
        exp_op_q.delete();
        exp_iter_q.delete();
    endtask

    ////////////////////
    // Main flow
    ////////////////////

    initial begin
        int          fd;
        int          n;
        int          wait_cnt;
        string       line;
        string       tag;
        logic [31:0] word;
        int          f_op;
        int          f_rd;
        int          f_rs1;
        int          f_rs2;
        int          f_iter;
        bit          have_case;
        seq_op_t     op;

        in_valid   = 1'b0;
        in_word    = '0;
        out_ready  = 1'b0;
        exp_seq_no = '0;
        driving    = 1'b0;
        saw_block  = 1'b0;
        case_cnt   = 0;
        check_cnt  = 0;
        error_cnt  = 0;
        have_case  = 1'b0;
        void'($urandom(32'hb856));

        // Reset may still be unknown at time zero, so wait for a clean high level
        wait_cnt = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            wait_cnt++;
            if (wait_cnt > WaitLimit) begin
                abort_run("reset was never released");
            end
        end
        @(negedge clk);

        fd = $fopen("test/frep_cases.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open test/frep_cases.txt");
        end
        // A T line closes the case before it, so each case runs once its lines are in
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%s", tag);
            if (n < 1 || tag.substr(0, 0) == "#") begin
                continue;
            end
            if (tag == "T") begin
                if (have_case) begin
                    run_case();
                end
                n = $sscanf(line, "%s %s %d %d", tag, case_name, case_gap, case_hold);
                if (n != 4) begin
                    abort_run({"badly formed case line: ", line});
                end
                have_case = 1'b1;
            end else if (tag == "W") begin
                n = $sscanf(line, "%s %h", tag, word);
                if (n != 2) begin
                    abort_run({"badly formed word line: ", line});
                end
                word_q.push_back(word);
            end else if (tag == "E") begin
                n = $sscanf(line, "%s %h %h %h %h %h", tag, f_op, f_rd, f_rs1, f_rs2, f_iter);
                if (n != 6) begin
                    abort_run({"badly formed expect line: ", line});
                end
                op        = '0;
                op.opcode = OpcodeWidth'(f_op);
                op.rd     = RegWidth'(f_rd);
                op.rs1    = RegWidth'(f_rs1);
                op.rs2    = RegWidth'(f_rs2);
                exp_op_q.push_back(op);
                exp_iter_q.push_back(RepWidth'(f_iter));
            end else begin
                abort_run({"unknown line in cases file: ", line});
            end
        end
        $fclose(fd);
        if (have_case) begin
            run_case();
        end

        // Assertion failures in the bound ring buffer checker
        if (DUT.i_ring_buffer.i_chk.fail_cnt != 0) begin
            error_cnt += DUT.i_ring_buffer.i_chk.fail_cnt;
            $display("ring buffer checker reported %0d assertion failures",
                     DUT.i_ring_buffer.i_chk.fail_cnt);
        end

        $display("%0d cases, %0d checks, %0d errors", case_cnt, check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* test/frep_cases.txt */
# T name gap hold | W input word | E opcode rd rs1 rs2 iter
# gap is idle cycles after each word, hold 1 blocks the output until the input stalls
T plain 0 0
W 01010203
W 02040506
W 03070809
E 01 01 02 03 0
E 02 04 05 06 0
E 03 07 08 09 0
T loop 0 0
W 80030002
W 10111213
W 11212223
W 12313233
W 13414243
E 10 11 12 13 0
E 11 21 22 23 0
E 12 31 32 33 0
E 10 11 12 13 1
E 11 21 22 23 1
E 12 31 32 33 1
E 10 11 12 13 2
E 11 21 22 23 2
E 12 31 32 33 2
E 13 41 42 43 0
T slow 6 0
W 80030002
W 10111213
W 11212223
W 12313233
W 13414243
E 10 11 12 13 0
E 11 21 22 23 0
E 12 31 32 33 0
E 10 11 12 13 1
E 11 21 22 23 1
E 12 31 32 33 1
E 10 11 12 13 2
E 11 21 22 23 2
E 12 31 32 33 2
E 13 41 42 43 0
T stalls 0 0
W 80020002
W 20616263
W 21717273
W 22010101
W 80010001
W 23020202
E 20 61 62 63 0
E 21 71 72 73 0
E 20 61 62 63 1
E 21 71 72 73 1
E 20 61 62 63 2
E 21 71 72 73 2
E 22 01 01 01 0
E 23 02 02 02 0
E 23 02 02 02 1
T fill 0 1
W 30000000
W 30010000
W 30020000
W 30030000
W 30040000
W 30050000
W 30060000
W 30070000
W 30080000
W 30090000
W 300a0000
W 300b0000
W 300c0000
W 300d0000
W 300e0000
W 300f0000
W 30100000
W 30110000
E 30 00 00 00 0
E 30 01 00 00 0
E 30 02 00 00 0
E 30 03 00 00 0
E 30 04 00 00 0
E 30 05 00 00 0
E 30 06 00 00 0
E 30 07 00 00 0
E 30 08 00 00 0
E 30 09 00 00 0
E 30 0a 00 00 0
E 30 0b 00 00 0
E 30 0c 00 00 0
E 30 0d 00 00 0
E 30 0e 00 00 0
E 30 0f 00 00 0
E 30 10 00 00 0
E 30 11 00 00 0

/* list.f */
hdl/seq_pkg.sv
hdl/ring_buffer.sv
hdl/seq_decode.sv
hdl/seq_execute.sv
hdl/seq_result.sv
hdl/frep_sequencer.sv
test/tb_clk_gen.sv
test/frep_sequencer_chk.sv
test/frep_sequencer_tb.sv
